// File: Makefile
TOP := bcam_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

// File: rtl/bcam_array.sv
module bcam_array #(
  parameter int ENTRIES = 16
) (
    input logic        clk
  , input logic        reset
  , bcam_mem_if.array  mem
);
  import bcam_key_pkg::*;

  entry_t             words_q [ENTRIES];
  logic [ENTRIES-1:0] hit;

  // contents are swept by the core after reset
  always_ff @(posedge clk) begin
    if (mem.wen) begin
      words_q[mem.waddr] <= mem.wdata;
    end
  end

  // compare against contents before this cycle's write
  always_comb begin
    for (int i = 0; i < ENTRIES; i++) begin
      hit[i] = words_q[i][ENTRY_VALID] && (words_q[i][KEY_W-1:0] == mem.cmp_key);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      mem.match <= '0;
    end else if (mem.cen) begin
      mem.match <= hit;
    end else begin
      mem.match <= '0;
    end
  end

  // address from the core always lands inside the array
  a_waddr_range: assert property (
    @(posedge clk) disable iff (reset)
    mem.wen |-> (int'(mem.waddr) < ENTRIES)
  );

endmodule

// File: rtl/bcam_banks.sv
module bcam_banks #(
  parameter int BANKS   = 4,
  parameter int ENTRIES = 16
) (
    input  logic                                        clk
  , input  logic                                        reset
  , input  logic                    [BANKS-1:0]         in_valid
  , input  bcam_op_pkg::bcam_op_t   [BANKS-1:0]         in_op
  , input  bcam_key_pkg::fid_t      [BANKS-1:0]         in_fid
  , input  bcam_key_pkg::qid_t      [BANKS-1:0]         in_qid
  , input  bcam_key_pkg::hid_t      [BANKS-1:0]         in_hid
  , output logic                    [BANKS-1:0]         out_valid
  , output bcam_op_pkg::bcam_op_t   [BANKS-1:0]         out_op
  , output bcam_key_pkg::fid_t      [BANKS-1:0]         out_fid
  , output bcam_key_pkg::qid_t      [BANKS-1:0]         out_qid
  , output bcam_key_pkg::hid_t      [BANKS-1:0]         out_hid
  , output logic                    [BANKS-1:0]         out_hit
  , output logic                    [BANKS-1:0]         out_vac
  , output logic [bcam_op_pkg::BANK_ERR_W*BANKS:0]      error
  , output logic                    [BANKS-1:0]         init_active
  , output logic                    [BANKS-1:0]         notempty
);
  import bcam_key_pkg::*;
  import bcam_op_pkg::*;

  localparam int CW = $clog2(BANKS + 1);

  logic [BANKS-1:0][BANK_ERR_W-1:0] bank_err;
  logic [CW-1:0]                    hit_cnt;
  logic                             xbank_hit;

  for (genvar b = 0; b < BANKS; b++) begin : gen_bank
    bcam_mem_if #(.ENTRIES(ENTRIES)) mem_if ();

    bcam_core #(.ENTRIES(ENTRIES)) core_i (
        .clk         (clk)
      , .reset       (reset)
      , .in_valid    (in_valid[b])
      , .in_op       (in_op[b])
      , .in_fid      (in_fid[b])
      , .in_qid      (in_qid[b])
      , .in_hid      (in_hid[b])
      , .mem         (mem_if.core)
      , .out_valid   (out_valid[b])
      , .out_op      (out_op[b])
      , .out_fid     (out_fid[b])
      , .out_qid     (out_qid[b])
      , .out_hid     (out_hid[b])
      , .out_hit     (out_hit[b])
      , .out_vac     (out_vac[b])
      , .error       (bank_err[b])
      , .init_active (init_active[b])
      , .notempty    (notempty[b])
    );

    bcam_array #(.ENTRIES(ENTRIES)) array_i (
        .clk   (clk)
      , .reset (reset)
      , .mem   (mem_if.array)
    );
  end

  // same key hitting in more than one bank on a bank 0 lookup
  always_comb begin
    hit_cnt = '0;
    for (int b = 0; b < BANKS; b++) begin
      hit_cnt = hit_cnt + CW'(out_hit[b]);
    end
    xbank_hit = out_valid[0] && (out_op[0] == OP_LOOKUP) && (hit_cnt > CW'(1));
  end

  always_comb begin
    error[BANK_ERR_W*BANKS-1:0]             = bank_err;
    error[BANK_ERR_W*BANKS + ERR_XBANK_HIT] = xbank_hit;
  end

endmodule

// File: rtl/bcam_core.sv
module bcam_core #(
  parameter int ENTRIES = 16
) (
    input  logic                                  clk
  , input  logic                                  reset
  , input  logic                                  in_valid
  , input  bcam_op_pkg::bcam_op_t                 in_op
  , input  bcam_key_pkg::fid_t                    in_fid
  , input  bcam_key_pkg::qid_t                    in_qid
  , input  bcam_key_pkg::hid_t                    in_hid
  , bcam_mem_if.core                              mem
  , output logic                                  out_valid
  , output bcam_op_pkg::bcam_op_t                 out_op
  , output bcam_key_pkg::fid_t                    out_fid
  , output bcam_key_pkg::qid_t                    out_qid
  , output bcam_key_pkg::hid_t                    out_hid
  , output logic                                  out_hit
  , output logic                                  out_vac
  , output logic [bcam_op_pkg::BANK_ERR_W-1:0]    error
  , output logic                                  init_active
  , output logic                                  notempty
);
  import bcam_key_pkg::*;
  import bcam_op_pkg::*;

  localparam int AW = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

  core_state_t        state_q;
  logic [AW-1:0]      init_cnt_q;
  logic [ENTRIES-1:0] valid_q;
  logic [ENTRIES-1:0] valid_d;
  logic [ENTRIES-1:0] ins_set;
  logic [ENTRIES-1:0] match_m;
  logic [ENTRIES-1:0] rm_clr;
  logic [AW-1:0]      ins_addr;
  logic [AW-1:0]      rm_addr;
  logic               accept;
  logic               any_free;
  logic               ins_wen;
  logic               rm_wen;
  logic               s1_cmp;
  logic               multi_hit;
  key_t               in_key;

  // stage 1 payload
  logic     s1_valid;
  bcam_op_t s1_op;
  fid_t     s1_fid;
  key_t     s1_key;
  logic     s1_vac;

  // init sweep, one address per cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      state_q    <= ST_INIT;
      init_cnt_q <= '0;
    end else if (state_q == ST_INIT) begin
      init_cnt_q <= init_cnt_q + 1'b1;
      if (init_cnt_q == AW'(ENTRIES - 1)) begin
        state_q <= ST_RUN;
      end
    end
  end

  assign init_active = (state_q == ST_INIT);
  assign accept      = in_valid && (state_q == ST_RUN);
  assign in_key      = {in_qid, in_hid};

  // lowest free entry
  always_comb begin
    ins_addr = '0;
    for (int i = ENTRIES - 1; i >= 0; i--) begin
      if (!valid_q[i]) begin
        ins_addr = AW'(i);
      end
    end
  end

  assign any_free = ~&valid_q;
  assign ins_wen  = accept && (in_op == OP_INSERT) && any_free;
  assign ins_set  = ins_wen ? (ENTRIES'(1) << ins_addr) : '0;

  // match comes back in stage 1, masked by the bitmap
  assign s1_cmp    = s1_valid && ((s1_op == OP_LOOKUP) || (s1_op == OP_REMOVE));
  assign match_m   = s1_cmp ? (mem.match & valid_q) : '0;
  assign multi_hit = (match_m & (match_m - 1'b1)) != '0;
  assign rm_clr    = (s1_op == OP_REMOVE) ? match_m : '0;

  always_comb begin
    rm_addr = '0;
    for (int i = ENTRIES - 1; i >= 0; i--) begin
      if (rm_clr[i]) begin
        rm_addr = AW'(i);
      end
    end
  end

  // insert wins the write port, stale word stays hidden by the bitmap
  assign rm_wen  = (rm_clr != '0) && !ins_wen;
  assign valid_d = (valid_q & ~rm_clr) | ins_set;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  assign notempty = |valid_q;

  always_comb begin
    mem.wen   = 1'b0;
    mem.waddr = '0;
    mem.wdata = '0;
    if (state_q == ST_INIT) begin
      mem.wen   = 1'b1;
      mem.waddr = init_cnt_q;
    end else if (ins_wen) begin
      mem.wen   = 1'b1;
      mem.waddr = ins_addr;
      mem.wdata = entry_t'({1'b1, in_key});
    end else if (rm_wen) begin
      mem.wen   = 1'b1;
      mem.waddr = rm_addr;
    end
  end

  assign mem.cen     = accept && ((in_op == OP_LOOKUP) || (in_op == OP_REMOVE));
  assign mem.cmp_key = in_key;

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
      error     <= '0;
    end else begin
      s1_valid                <= accept;
      out_valid               <= s1_valid;
      error[ERR_MULTI_HIT]    <= multi_hit;
      error[ERR_OP_IN_INIT]   <= in_valid && (state_q == ST_INIT);
    end
  end

  always_ff @(posedge clk) begin
    s1_op   <= in_op;
    s1_fid  <= in_fid;
    s1_key  <= in_key;
    s1_vac  <= any_free;
    out_op  <= s1_op;
    out_fid <= s1_fid;
    out_qid <= s1_key[HID_W +: QID_W];
    out_hid <= s1_key[HID_W-1:0];
    out_hit <= |match_m;
    out_vac <= s1_vac;
  end

  // a valid word only lands in an entry that the bitmap shows free
  a_no_insert_full: assert property (
    @(posedge clk) disable iff (reset)
    (mem.wen && mem.wdata[ENTRY_VALID]) |-> !valid_q[mem.waddr]
  );

  a_no_out_in_init: assert property (
    @(posedge clk) disable iff (reset)
    (state_q == ST_INIT) |-> !out_valid
  );

endmodule

// File: rtl/bcam_key_pkg.sv
package bcam_key_pkg;

  localparam int QID_W = 7;
  localparam int HID_W = 16;
  localparam int FID_W = 11;

  // flow key is qid on top of hid
  localparam int KEY_W = QID_W + HID_W;

  // storage word carries a valid bit above the key
  localparam int ENTRY_W     = KEY_W + 1;
  localparam int ENTRY_VALID = KEY_W;

  typedef logic [QID_W-1:0] qid_t;
  typedef logic [HID_W-1:0] hid_t;

  // opaque flow tag, passed through untouched
  typedef logic [FID_W-1:0] fid_t;

  typedef logic [KEY_W-1:0]   key_t;
  typedef logic [ENTRY_W-1:0] entry_t;

endpackage

// File: rtl/bcam_mem_if.sv
interface bcam_mem_if #(
  parameter int ENTRIES = 16
);
  import bcam_key_pkg::*;

  localparam int AW = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

  // write port
  logic          wen;
  logic [AW-1:0] waddr;
  entry_t        wdata;

  // compare port, match returns one cycle after cen
  logic               cen;
  key_t               cmp_key;
  logic [ENTRIES-1:0] match;

  modport core (
    output wen, waddr, wdata, cen, cmp_key,
    input  match
  );

  modport array (
    input  wen, waddr, wdata, cen, cmp_key,
    output match
  );

endinterface

// File: rtl/bcam_op_pkg.sv
package bcam_op_pkg;

  typedef enum logic [1:0] {
    OP_NOP    = 2'd0,
    OP_LOOKUP = 2'd1,
    OP_INSERT = 2'd2,
    OP_REMOVE = 2'd3
  } bcam_op_t;

  // per-bank error vector
  localparam int BANK_ERR_W     = 2;
  localparam int ERR_MULTI_HIT  = 0;
  localparam int ERR_OP_IN_INIT = 1;

  // offset above the per-bank error field in the top error vector
  localparam int ERR_XBANK_HIT = 0;

  // bank sweeps storage before accepting ops
  typedef enum logic {
    ST_INIT,
    ST_RUN
  } core_state_t;

endpackage

// File: tb.f
rtl/bcam_key_pkg.sv
rtl/bcam_op_pkg.sv
rtl/bcam_mem_if.sv
rtl/bcam_array.sv
rtl/bcam_core.sv
rtl/bcam_banks.sv
testbench/bcam_tb.sv

// File: testbench/bcam_patterns.txt
# mask op fid qid hid exp_hit exp_vac exp_notempty flags (all hex)
# op 1 lookup 2 insert 3 remove, flags bit0 back to back, bit1 multi hit, bit2 cross bank
1 2 001 05 1234 0 1 1 0
1 1 002 05 1234 1 1 1 1
1 1 003 05 9999 0 1 1 0
2 2 004 11 0abc 0 1 1 0
2 1 005 11 0abc 1 1 1 0
2 3 006 11 0abc 1 1 0 0
2 1 007 11 0abc 0 1 0 1
2 3 008 11 0abc 0 1 0 0
4 2 010 20 0000 0 1 1 0
4 2 011 20 0001 0 1 1 0
4 2 012 20 0002 0 1 1 0
4 2 013 20 0003 0 1 1 0
4 2 014 20 0004 0 1 1 0
4 2 015 20 0005 0 1 1 0
4 2 016 20 0006 0 1 1 0
4 2 017 20 0007 0 1 1 0
4 2 018 20 0008 0 1 1 0
4 2 019 20 0009 0 1 1 0
4 2 01a 20 000a 0 1 1 0
4 2 01b 20 000b 0 1 1 0
4 2 01c 20 000c 0 1 1 0
4 2 01d 20 000d 0 1 1 0
4 2 01e 20 000e 0 1 1 0
4 2 01f 20 000f 0 1 1 0
4 2 020 20 0010 0 0 1 0
4 1 021 20 0010 0 0 1 0
4 1 022 20 0005 1 0 1 0
8 2 030 20 0010 0 1 1 0
1 1 031 05 1234 1 1 1 0
8 2 040 0a beef 0 1 1 0
8 2 041 0a beef 0 1 1 0
8 1 042 0a beef 1 1 1 2
2 2 050 05 1234 0 1 1 0
3 1 051 05 1234 1 1 1 4
1 3 060 05 1234 1 1 0 0
1 1 061 05 1234 0 1 0 1
2 1 062 05 1234 1 1 1 0

// File: testbench/bcam_tb.sv
module bcam_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import bcam_key_pkg::*;
  import bcam_op_pkg::*;

  localparam int BANKS   = 4;
  localparam int ENTRIES = 16;
  localparam int XB_BIT  = BANK_ERR_W * BANKS + ERR_XBANK_HIT;

  typedef struct packed {
    bcam_op_t op;
    fid_t     fid;
    key_t     key;
    logic     hit;
    logic     vac;
    logic     ne;
    logic     mh;
    logic     xb;
  } expect_t;

  logic                     clk;
  logic                     reset;
  logic     [BANKS-1:0]     in_valid;
  bcam_op_t [BANKS-1:0]     in_op;
  fid_t     [BANKS-1:0]     in_fid;
  qid_t     [BANKS-1:0]     in_qid;
  hid_t     [BANKS-1:0]     in_hid;
  logic     [BANKS-1:0]     out_valid;
  bcam_op_t [BANKS-1:0]     out_op;
  fid_t     [BANKS-1:0]     out_fid;
  qid_t     [BANKS-1:0]     out_qid;
  hid_t     [BANKS-1:0]     out_hid;
  logic     [BANKS-1:0]     out_hit;
  logic     [BANKS-1:0]     out_vac;
  logic [BANK_ERR_W*BANKS:0] error;
  logic     [BANKS-1:0]     init_active;
  logic     [BANKS-1:0]     notempty;

  expect_t     exp_q [BANKS][$];
  int          age [BANKS] = '{default: 0};
  int          checks = 0;
  int          errors = 0;
  int          timeouts = 0;
  bit          abort = 1'b0;
  int unsigned lcg_state = 97;

  bcam_banks #(.BANKS(BANKS), .ENTRIES(ENTRIES)) bcam_banks_i (.*);

  always #4 clk = ~clk;

  function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
  endfunction

  function automatic bit ops_pending();
    int n;
    n = 0;
    for (int b = 0; b < BANKS; b++) begin
      n += exp_q[b].size();
    end
    return n != 0;
  endfunction

  task automatic finish_run();
    $display("checks %0d, mismatches %0d, timeouts %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  endtask

  // stops further stimulus, the run then ends through finish_run
  task automatic timed_out(string what);
    $display("timeout at %0t: %s", $time, what);
    timeouts++;
    abort = 1'b1;
  endtask

  task automatic check_key(string name, key_t got, key_t exp);
    checks++;
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_fid(string name, fid_t got, fid_t exp);
    checks++;
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_op(string name, bcam_op_t got, bcam_op_t exp);
    checks++;
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    checks++;
    if (got !== exp) begin
      $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  // sampled at the falling edge, half a cycle after outputs settle
  task automatic check_outputs();
    expect_t e;
    for (int b = 0; b < BANKS; b++) begin
      if (out_valid[b]) begin
        if (exp_q[b].size() == 0) begin
          $display("error at %0t: bank %0d gave out_valid with no op pending", $time, b);
          errors++;
        end else begin
          e = exp_q[b].pop_front();
          age[b] = 0;
          check_op($sformatf("bank %0d op", b), out_op[b], e.op);
          check_fid($sformatf("bank %0d fid", b), out_fid[b], e.fid);
          check_key($sformatf("bank %0d key", b), {out_qid[b], out_hid[b]}, e.key);
          check_flag($sformatf("bank %0d hit", b), out_hit[b], e.hit);
          check_flag($sformatf("bank %0d vac", b), out_vac[b], e.vac);
          check_flag($sformatf("bank %0d notempty", b), notempty[b], e.ne);
          check_flag($sformatf("bank %0d multi hit", b),
                     error[b*BANK_ERR_W + ERR_MULTI_HIT], e.mh);
          check_flag($sformatf("bank %0d op in init", b),
                     error[b*BANK_ERR_W + ERR_OP_IN_INIT], 1'b0);
          if (b == 0) begin
            check_flag("cross bank hit", error[XB_BIT], e.xb);
          end
        end
      end else if (exp_q[b].size() != 0 && !abort) begin
        age[b]++;
        if (age[b] > 10) begin
          timed_out($sformatf("bank %0d gave no out_valid", b));
        end
      end
    end
  endtask

  // inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(negedge clk);
    check_outputs();
    @(posedge clk);
    #1;
  endtask

  task automatic wait_init();
    int cycles;
    cycles = 0;
    repeat (5) @(posedge clk);
    #1;
    reset       = 1'b0;
    in_valid[1] = 1'b1;
    in_op[1]    = OP_LOOKUP;
    @(negedge clk);
    if (init_active == '1) begin
      cycles++;
    end
    @(posedge clk);
    #1;
    in_valid = '0;
    @(negedge clk);
    check_flag("bank 1 op in init", error[BANK_ERR_W + ERR_OP_IN_INIT], 1'b1);
    while (init_active != '0) begin
      if (cycles >= 40) begin
        timed_out("init sweep did not finish");
        return;
      end
      if (init_active == '1) begin
        cycles++;
      end
      check_flag("notempty in init", |notempty, 1'b0);
      check_flag("out_valid in init", |out_valid, 1'b0);
      @(negedge clk);
    end
    checks++;
    if (cycles != ENTRIES) begin
      $display("mismatch at %0t: init lasted %0d cycles expected %0d", $time, cycles, ENTRIES);
      errors++;
    end
  endtask

  task automatic run_patterns();
    int          fd;
    int          n;
    int          idle;
    int          drain;
    string       line;
    logic [31:0] mask_v, op_v, fid_v, qid_v, hid_v, hit_v, vac_v, ne_v, flags_v;
    expect_t     e;
    fd = $fopen("testbench/bcam_patterns.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open testbench/bcam_patterns.txt");
      errors++;
      return;
    end
    while (!$feof(fd) && !abort) begin
      line = "";
      n = $fgets(line, fd);
      if (line.len() == 0 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", mask_v, op_v, fid_v, qid_v, hid_v,
                  hit_v, vac_v, ne_v, flags_v);
      if (n != 9) begin
        continue;
      end
      // flag bit 0 forces issue in the very next cycle
      idle = flags_v[0] ? 0 : int'(lcg_next() % 3);
      repeat (idle) begin
        next_cycle();
        in_valid = '0;
      end
      next_cycle();
      in_valid = '0;
      e = '{op: bcam_op_t'(op_v[1:0]), fid: fid_v[FID_W-1:0],
            key: {qid_v[QID_W-1:0], hid_v[HID_W-1:0]}, hit: hit_v[0], vac: vac_v[0],
            ne: ne_v[0], mh: flags_v[1], xb: flags_v[2]};
      for (int b = 0; b < BANKS; b++) begin
        if (mask_v[b]) begin
          in_valid[b] = 1'b1;
          in_op[b]    = e.op;
          in_fid[b]   = e.fid;
          in_qid[b]   = qid_v[QID_W-1:0];
          in_hid[b]   = hid_v[HID_W-1:0];
          exp_q[b].push_back(e);
        end
      end
    end
    $fclose(fd);
    next_cycle();
    in_valid = '0;
    drain = 0;
    while (ops_pending() && !abort) begin
      if (drain >= 20) begin
        timed_out("outputs did not drain");
      end else begin
        next_cycle();
        drain++;
      end
    end
  endtask

  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    in_valid = '0;
    in_fid   = '0;
    in_qid   = '0;
    in_hid   = '0;
    for (int b = 0; b < BANKS; b++) begin
      in_op[b] = OP_NOP;
    end
    wait_init();
    if (!abort) begin
      run_patterns();
    end
    finish_run();
  end

endmodule
